// File: project.f
src/mipsPkg.sv
src/uartLink.sv
src/controlFsm.sv
src/cycleCounter.sv
src/datapath.sv
src/uart.sv
src/mips150.sv
verif/memModel.sv
verif/mips150Tb.sv

// File: Bender.yml
package:
  name: mips150

sources:
  - files:
      - src/mipsPkg.sv
      - src/uartLink.sv
      - src/controlFsm.sv
      - src/cycleCounter.sv
      - src/datapath.sv
      - src/uart.sv
      - src/mips150.sv
  - target: test
    files:
      - verif/memModel.sv
      - verif/mips150Tb.sv

// File: verif/mips150Tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips150Tb;

   localparam int TxDepth      = 4;
   localparam int ClocksPerBit = 16;
   localparam int StartTimeout = 20000;
   localparam int StoreTimeout = 50000;
   localparam logic [7:0] RxByte = 8'h9e;

   localparam int ExactValue = 0;
   localparam int AtLeast    = 1;
   localparam int AtMost     = 2;

   localparam logic [5:0] OpBeq   = 6'h04;
   localparam logic [5:0] OpBne   = 6'h05;
   localparam logic [5:0] OpAddiu = 6'h09;
   localparam logic [5:0] OpOri   = 6'h0d;
   localparam logic [5:0] OpLui   = 6'h0f;
   localparam logic [5:0] OpLw    = 6'h23;
   localparam logic [5:0] OpSw    = 6'h2b;
   localparam logic [5:0] FnAddu  = 6'h21;
   localparam logic [5:0] FnSubu  = 6'h23;
   localparam logic [5:0] FnAnd   = 6'h24;
   localparam logic [5:0] FnOr    = 6'h25;
   localparam logic [5:0] FnSlt   = 6'h2a;

   logic        clk;
   logic        reset;
   logic        serialRx;
   logic        serialTx;
   logic [31:0] dcacheAddr;
   logic [31:0] icacheAddr;
   logic [3:0]  dcacheWe;
   logic        dcacheRe;
   logic        icacheRe;
   logic [31:0] dcacheDin;
   logic [31:0] dcacheDout;
   logic [31:0] instruction;
   logic        stall;

   logic [7:0]  txBytes [6];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   int          expBound [$];
   string       expName [$];
   int          pcIdx;

   mips150 #(
      .TxDepth      (TxDepth),
      .ClocksPerBit (ClocksPerBit)
   ) mips150_i (
      .clk         (clk),
      .reset       (reset),
      .serialRx    (serialRx),
      .serialTx    (serialTx),
      .dcacheAddr  (dcacheAddr),
      .icacheAddr  (icacheAddr),
      .dcacheWe    (dcacheWe),
      .dcacheRe    (dcacheRe),
      .icacheRe    (icacheRe),
      .dcacheDin   (dcacheDin),
      .dcacheDout  (dcacheDout),
      .instruction (instruction),
      .stall       (stall)
   );

   memModel memModel_i (
      .clk         (clk),
      .reset       (reset),
      .icacheRe    (icacheRe),
      .icacheAddr  (icacheAddr),
      .dcacheRe    (dcacheRe),
      .dcacheWe    (dcacheWe),
      .dcacheAddr  (dcacheAddr),
      .dcacheDin   (dcacheDin),
      .instruction (instruction),
      .dcacheDout  (dcacheDout),
      .stall       (stall)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abortRun();
      $display("Some tests failed");
      $fatal(1);
   endtask

   function automatic logic [31:0] rType(
      input logic [4:0] rs,
      input logic [4:0] rt,
      input logic [4:0] rd,
      input logic [5:0] funct
   );
      return {6'h00, rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic logic [31:0] iType(
      input logic [5:0]  op,
      input logic [4:0]  rs,
      input logic [4:0]  rt,
      input logic [15:0] imm
   );
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] jType(input int target);
      return {6'h02, target[25:0]}; // word index with upper pc bits zero
   endfunction

   function automatic logic [31:0] upperImm(input logic [15:0] imm);
      return {imm, 16'h0000};
   endfunction

   function automatic logic [31:0] orImm(input logic [31:0] a, input logic [15:0] imm);
      return a | {16'h0000, imm}; // zero extended
   endfunction

   function automatic logic [31:0] addImm(input logic [31:0] a, input logic [15:0] imm);
      return a + {{16{imm[15]}}, imm};
   endfunction

   function automatic logic [31:0] setLess(input logic [31:0] a, input logic [31:0] b);
      return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
   endfunction

   task automatic emit(input logic [31:0] word);
      memModel_i.imem[pcIdx] = word;
      pcIdx++;
   endtask

   task automatic expectStore(
      input string       name,
      input logic [31:0] addr,
      input logic [31:0] data,
      input int          bound
   );
      expName.push_back(name);
      expAddr.push_back(addr);
      expData.push_back(data);
      expBound.push_back(bound);
   endtask

   // result in r3 goes to a low data address
   task automatic aluCheck(
      input string       name,
      input logic [31:0] word,
      input logic [15:0] addr,
      input logic [31:0] expected
   );
      emit(word);
      emit(iType(OpSw, 5'd0, 5'd3, addr));
      expectStore(name, {16'h0000, addr}, expected, ExactValue);
   endtask

   task automatic emitPoll(input logic [4:0] maskReg);
      emit(iType(OpLw, 5'd8, 5'd10, 16'h0000)); // status
      emit(rType(5'd10, maskReg, 5'd10, FnAnd));
      emit(iType(OpBeq, 5'd10, 5'd0, 16'hfffd)); // back to the status read
   endtask

   task automatic buildProgram();
      logic [31:0] a;
      logic [31:0] b;
      a = orImm(upperImm(16'h7000), 16'h1234);
      b = orImm(upperImm(16'hf000), 16'h00ff);
      emit(iType(OpLui, 5'd0, 5'd1, 16'h7000));
      emit(iType(OpOri, 5'd1, 5'd1, 16'h1234));
      emit(iType(OpLui, 5'd0, 5'd2, 16'hf000));
      emit(iType(OpOri, 5'd2, 5'd2, 16'h00ff));
      aluCheck("addu", rType(5'd1, 5'd2, 5'd3, FnAddu), 16'h0100, a + b);
      aluCheck("subu", rType(5'd1, 5'd2, 5'd3, FnSubu), 16'h0104, a - b);
      aluCheck("and", rType(5'd1, 5'd2, 5'd3, FnAnd), 16'h0108, a & b);
      aluCheck("or", rType(5'd1, 5'd2, 5'd3, FnOr), 16'h010c, a | b);
      aluCheck("slt", rType(5'd2, 5'd1, 5'd3, FnSlt), 16'h0110, setLess(b, a));
      aluCheck("addiu", iType(OpAddiu, 5'd1, 5'd3, 16'hfffb), 16'h0114, addImm(a, 16'hfffb));
      aluCheck("ori", iType(OpOri, 5'd2, 5'd3, 16'h8001), 16'h0118, orImm(b, 16'h8001));
      aluCheck("lui", iType(OpLui, 5'd0, 5'd3, 16'habcd), 16'h011c, upperImm(16'habcd));

      emit(iType(OpAddiu, 5'd0, 5'd4, 16'h2468));
      emit(iType(OpSw, 5'd0, 5'd4, 16'h0140));
      expectStore("store word", 32'h140, 32'h2468, ExactValue);
      emit(iType(OpLw, 5'd0, 5'd5, 16'h0140));
      emit(iType(OpAddiu, 5'd5, 5'd5, 16'h0001));
      emit(iType(OpSw, 5'd0, 5'd5, 16'h0140));
      expectStore("load round trip", 32'h140, 32'h2469, ExactValue);

      emit(iType(OpAddiu, 5'd0, 5'd6, 16'h0007));
      emit(iType(OpAddiu, 5'd0, 5'd7, 16'h0007));
      emit(iType(OpBeq, 5'd6, 5'd7, 16'h0001));
      emit(iType(OpSw, 5'd0, 5'd6, 16'h0180)); // skipped
      emit(iType(OpSw, 5'd0, 5'd6, 16'h0184));
      expectStore("beq taken", 32'h184, 32'd7, ExactValue);
      emit(iType(OpBne, 5'd6, 5'd7, 16'h0001));
      emit(iType(OpSw, 5'd0, 5'd6, 16'h0188));
      expectStore("bne not taken", 32'h188, 32'd7, ExactValue);
      emit(jType(pcIdx + 2));
      emit(iType(OpSw, 5'd0, 5'd6, 16'h018c)); // skipped
      emit(iType(OpSw, 5'd0, 5'd6, 16'h0190));
      expectStore("jump", 32'h190, 32'd7, ExactValue);

      emit(iType(OpLui, 5'd0, 5'd8, 16'h8000)); // I/O base
      emit(iType(OpAddiu, 5'd0, 5'd9, 16'h0001));
      for (int k = 0; k < 6; k++) begin
         emitPoll(5'd9);
         emit(iType(OpAddiu, 5'd0, 5'd11, {8'h00, txBytes[k]}));
         emit(iType(OpSw, 5'd8, 5'd11, 16'h0008));
      end

      emit(iType(OpAddiu, 5'd0, 5'd9, 16'h0002));
      emitPoll(5'd9);
      emit(iType(OpLw, 5'd8, 5'd12, 16'h0004));
      emit(iType(OpAddiu, 5'd12, 5'd12, 16'h0001));
      emit(iType(OpSw, 5'd0, 5'd12, 16'h01c0));
      expectStore("receive data", 32'h1c0, {24'h0, RxByte} + 32'd1, ExactValue);
      emit(iType(OpLw, 5'd8, 5'd13, 16'h0000));
      emit(rType(5'd13, 5'd9, 5'd13, FnAnd));
      emit(iType(OpSw, 5'd0, 5'd13, 16'h01c4));
      expectStore("receive status after read", 32'h1c4, 32'd0, ExactValue);

      emit(iType(OpSw, 5'd8, 5'd0, 16'h0018)); // clear count
      emit(iType(OpLw, 5'd8, 5'd14, 16'h0010));
      for (int k = 0; k < 10; k++) begin
         emit(iType(OpAddiu, 5'd0, 5'd15, 16'(k)));
      end
      emit(iType(OpLw, 5'd8, 5'd16, 16'h0010));
      emit(rType(5'd16, 5'd14, 5'd17, FnSubu));
      emit(iType(OpSw, 5'd0, 5'd17, 16'h01d0));
      expectStore("cycle count", 32'h1d0, 32'd40, AtLeast);
      emit(iType(OpSw, 5'd0, 5'd14, 16'h01d4));
      expectStore("count after clear", 32'h1d4, 32'd100, AtMost); // read a few cycles after the clear
      emit(jType(pcIdx)); // park
   endtask

   task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
      string       name;
      logic [31:0] eAddr;
      logic [31:0] eData;
      int          bound;
      if (expAddr.size() == 0) begin
         $display("store to %h after the last expected store", addr);
         abortRun();
      end
      name  = expName.pop_front();
      eAddr = expAddr.pop_front();
      eData = expData.pop_front();
      bound = expBound.pop_front();
      assert (addr == eAddr) else begin
         $display("[FAIL] %s address: expected %h, actual %h", name, eAddr, addr);
         abortRun();
      end
      case (bound)
         AtLeast: begin
            assert (data >= eData) else begin
               $display("[FAIL] %s: expected at least %0d, actual %0d", name, eData, data);
               abortRun();
            end
         end
         AtMost: begin
            assert (data <= eData) else begin
               $display("[FAIL] %s: expected at most %0d, actual %0d", name, eData, data);
               abortRun();
            end
         end
         default: begin
            assert (data == eData) else begin
               $display("[FAIL] %s: expected %h, actual %h", name, eData, data);
               abortRun();
            end
         end
      endcase
   endtask

   task automatic decodeByte(output logic [7:0] value);
      int waited;
      waited = 0;
      while (serialTx !== 1'b0 && waited < StartTimeout) begin
         @(negedge clk);
         waited++;
      end
      if (serialTx !== 1'b0) begin
         $display("timed out waiting for a start bit on serialTx");
         abortRun();
      end
      repeat (ClocksPerBit / 2) @(negedge clk); // middle of the start bit
      assert (serialTx == 1'b0) else begin
         $display("start bit on serialTx ended early");
         abortRun();
      end
      for (int i = 0; i < 8; i++) begin
         repeat (ClocksPerBit) @(negedge clk);
         value[i] = serialTx;
      end
      repeat (ClocksPerBit) @(negedge clk);
      assert (serialTx == 1'b1) else begin
         $display("missing stop bit on serialTx");
         abortRun();
      end
   endtask

   task automatic sendByte(input logic [7:0] value);
      logic [9:0] frame;
      frame = {1'b1, value, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         serialRx <= frame[i];
         repeat (ClocksPerBit - 1) @(posedge clk);
      end
   endtask

   always @(negedge clk) begin
      if (!reset && !stall && dcacheWe != 4'h0) begin
         checkStore(dcacheAddr, dcacheDin);
      end
   end

   enableCheck: assert property (@(posedge clk) disable iff (reset)
      dcacheWe == 4'h0 || dcacheWe == 4'hf)
   else begin
      $display("[FAIL] byte enables: expected 0 or f, actual %h", $sampled(dcacheWe));
      abortRun();
   end

   // one instruction in flight, so fetch and data access never overlap
   accessCheck: assert property (@(posedge clk) disable iff (reset)
      $onehot0({icacheRe, dcacheRe, dcacheWe != 4'h0}))
   else begin
      $display("more than one memory access requested in the same cycle");
      abortRun();
   end

   fetchCheck: assert property (@(posedge clk) disable iff (reset)
      icacheRe |-> icacheAddr[1:0] == 2'b00 && icacheAddr < 32'(4 * pcIdx))
   else begin
      $display("[FAIL] fetch address: expected aligned and below %h, actual %h",
               32'(4 * pcIdx), $sampled(icacheAddr));
      abortRun();
   end

   initial begin
      logic [7:0] got;
      int         waited;
      reset    = 1'b1;
      serialRx = 1'b1; // idle line
      pcIdx    = 0;
      txBytes  = '{8'h55, 8'ha3, 8'h00, 8'hff, 8'h3c, 8'h81};
      buildProgram();
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      for (int k = 0; k < 6; k++) begin
         decodeByte(got);
         assert (got == txBytes[k]) else begin
            $display("[FAIL] transmit byte %0d: expected %h, actual %h", k, txBytes[k], got);
            abortRun();
         end
      end

      sendByte(RxByte);
      waited = 0;
      while (expAddr.size() != 0 && waited < StoreTimeout) begin
         @(negedge clk);
         waited++;
      end
      if (expAddr.size() != 0) begin
         $display("timed out waiting for %0d more program stores", expAddr.size());
         abortRun();
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: verif/memModel.sv
`timescale 1ns/1ps
`default_nettype none

module memModel #(
   parameter logic [31:0] Seed = 32'h9c68_cd78
) (
   input  wire         clk,
   input  wire         reset,
   input  wire         icacheRe,
   input  wire  [31:0] icacheAddr,
   input  wire         dcacheRe,
   input  wire  [3:0]  dcacheWe,
   input  wire  [31:0] dcacheAddr,
   input  wire  [31:0] dcacheDin,
   output logic [31:0] instruction,
   output logic [31:0] dcacheDout,
   output logic        stall
);

   logic [31:0] imem [256]; // loaded by the testbench
   logic [31:0] dmem [256];
   logic [31:0] lcgState = Seed;
   logic [31:0] instrReg = '0;
   logic [31:0] doutReg  = '0;
   logic        stallReg = 1'b0;

   function automatic logic [31:0] lcgNext(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   assign instruction = instrReg;
   assign dcacheDout  = doutReg;
   assign stall       = stallReg;

   always @(posedge clk) begin
      if (reset) begin
         lcgState <= Seed;
         stallReg <= 1'b0;
      end else begin
         lcgState <= lcgNext(lcgState);
         stallReg <= (lcgState[31:30] == 2'b00); // about one cycle in four
      end
   end

   always @(posedge clk) begin
      if (icacheRe) begin
         instrReg <= imem[icacheAddr[9:2]];
      end
      if (dcacheRe) begin
         doutReg <= dmem[dcacheAddr[9:2]];
      end
      if (!stallReg) begin // busy memory takes no write
         for (int lane = 0; lane < 4; lane++) begin
            if (dcacheWe[lane]) begin
               dmem[dcacheAddr[9:2]][8*lane +: 8] <= dcacheDin[8*lane +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: src/mips150.sv
`timescale 1ns/1ps
`default_nettype none

module mips150 #(
   parameter int TxDepth      = 4,
   parameter int ClocksPerBit = 16
) (
   input  wire         clk,
   input  wire         reset,
   input  wire         serialRx,
   output logic        serialTx,
   output logic [31:0] dcacheAddr,
   output logic [31:0] icacheAddr,
   output logic [3:0]  dcacheWe,
   output logic        dcacheRe,
   output logic        icacheRe,
   output logic [31:0] dcacheDin,
   input  wire  [31:0] dcacheDout,
   input  wire  [31:0] instruction,
   input  wire         stall
);
   import mipsPkg::*;

   Instruction  instr;
   PcSel        pcSel;
   AluOp        aluOp;
   logic        irWrite;
   logic        pcWrite;
   logic        regWrite;
   logic        regDst;
   logic        aluSrcImm;
   logic        signExtend;
   logic        memToReg;
   logic        addrLatch;
   logic        ioRead;
   logic        ioWrite;
   logic        branchEqual;
   logic        isIo;
   logic        counterClear;
   logic [31:0] count;

   uartLink link ();

   controlFsm controlFsm_i (
      .clk         (clk),
      .reset       (reset),
      .stall       (stall),
      .instr       (instr),
      .branchEqual (branchEqual),
      .isIo        (isIo),
      .irWrite     (irWrite),
      .pcWrite     (pcWrite),
      .pcSel       (pcSel),
      .regWrite    (regWrite),
      .regDst      (regDst),
      .aluSrcImm   (aluSrcImm),
      .signExtend  (signExtend),
      .aluOp       (aluOp),
      .memToReg    (memToReg),
      .addrLatch   (addrLatch),
      .ioRead      (ioRead),
      .ioWrite     (ioWrite),
      .icacheRe    (icacheRe),
      .dcacheRe    (dcacheRe),
      .dcacheWe    (dcacheWe)
   );

   cycleCounter cycleCounter_i (
      .clk   (clk),
      .reset (reset),
      .clear (counterClear),
      .count (count)
   );

   datapath #(
      .TxDepth (TxDepth)
   ) datapath_i (
      .clk          (clk),
      .reset        (reset),
      .stall        (stall),
      .irWrite      (irWrite),
      .pcWrite      (pcWrite),
      .pcSel        (pcSel),
      .regWrite     (regWrite),
      .regDst       (regDst),
      .aluSrcImm    (aluSrcImm),
      .signExtend   (signExtend),
      .aluOp        (aluOp),
      .memToReg     (memToReg),
      .addrLatch    (addrLatch),
      .ioRead       (ioRead),
      .ioWrite      (ioWrite),
      .dcacheDout   (dcacheDout),
      .instruction  (instruction),
      .count        (count),
      .instr        (instr),
      .branchEqual  (branchEqual),
      .isIo         (isIo),
      .icacheAddr   (icacheAddr),
      .dcacheAddr   (dcacheAddr),
      .dcacheDin    (dcacheDin),
      .counterClear (counterClear),
      .link         (link.core)
   );

   uart #(
      .ClocksPerBit (ClocksPerBit),
      .TxDepth      (TxDepth)
   ) uart_i (
      .clk      (clk),
      .reset    (reset),
      .serialRx (serialRx),
      .serialTx (serialTx),
      .link     (link.serial)
   );

endmodule

`default_nettype wire

// File: src/uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart #(
   parameter int ClocksPerBit = 16,
   parameter int TxDepth      = 4
) (
   input  wire   clk,
   input  wire   reset,
   input  wire   serialRx,
   output logic  serialTx,
   uartLink.serial link
);

   localparam int PtrWidth   = $clog2(TxDepth);
   localparam int CountWidth = $clog2(TxDepth + 1);
   localparam int TimerWidth = $clog2(ClocksPerBit);
   localparam logic [TimerWidth-1:0] BitTicks  = TimerWidth'(ClocksPerBit - 1);
   localparam logic [TimerWidth-1:0] HalfTicks = TimerWidth'(ClocksPerBit / 2 - 1);

   logic [7:0]            fifoMem [TxDepth];
   logic [PtrWidth-1:0]   wrPtr;
   logic [PtrWidth-1:0]   rdPtr;
   logic [CountWidth-1:0] fifoCount;
   logic                  txLoad;
   logic                  txBusy;
   logic [9:0]            txShift;
   logic [3:0]            txBitsLeft;
   logic [TimerWidth-1:0] txTimer;

   logic [1:0]            rxSync;
   logic                  rxIn;
   logic                  rxBusy;
   logic [TimerWidth-1:0] rxTimer;
   logic [3:0]            rxBitCount;
   logic                  rxSample;
   logic                  rxDone;
   logic [7:0]            rxByte;
   logic [7:0]            rxHold;
   logic                  rxValid;

   assign txBusy        = (txBitsLeft != 4'd0);
   assign txLoad        = !txBusy && fifoCount != '0;
   assign link.txCredit = txLoad; // byte leaves the FIFO
   assign serialTx      = txShift[0];

   always_ff @(posedge clk) begin
      if (link.txPush) begin
         fifoMem[wrPtr] <= link.txData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wrPtr     <= '0;
         rdPtr     <= '0;
         fifoCount <= '0;
      end else begin
         if (link.txPush) begin
            wrPtr <= (wrPtr == PtrWidth'(TxDepth - 1)) ? '0 : wrPtr + 1'b1;
         end
         if (txLoad) begin
            rdPtr <= (rdPtr == PtrWidth'(TxDepth - 1)) ? '0 : rdPtr + 1'b1;
         end
         if (link.txPush && !txLoad) begin
            fifoCount <= fifoCount + 1'b1;
         end else if (txLoad && !link.txPush) begin
            fifoCount <= fifoCount - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         txShift    <= '1; // line idles high
         txBitsLeft <= 4'd0;
         txTimer    <= '0;
      end else if (txLoad) begin
         txShift    <= {1'b1, fifoMem[rdPtr], 1'b0};
         txBitsLeft <= 4'd10;
         txTimer    <= BitTicks;
      end else if (txBusy) begin
         if (txTimer == '0) begin
            txShift    <= {1'b1, txShift[9:1]};
            txBitsLeft <= txBitsLeft - 4'd1;
            txTimer    <= BitTicks;
         end else begin
            txTimer <= txTimer - 1'b1;
         end
      end
   end

   assign rxIn     = rxSync[1];
   assign rxSample = rxBusy && rxTimer == '0;
   assign rxDone   = rxSample && rxBitCount == 4'd9; // stop bit

   always_ff @(posedge clk) begin
      if (reset) begin
         rxSync     <= 2'b11;
         rxBusy     <= 1'b0;
         rxTimer    <= '0;
         rxBitCount <= 4'd0;
         rxValid    <= 1'b0;
      end else begin
         rxSync <= {rxSync[0], serialRx};
         if (!rxBusy) begin
            if (!rxIn) begin
               rxBusy     <= 1'b1;
               rxTimer    <= HalfTicks; // aim at mid bit
               rxBitCount <= 4'd0;
            end
         end else if (!rxSample) begin
            rxTimer <= rxTimer - 1'b1;
         end else begin
            rxTimer    <= BitTicks;
            rxBitCount <= rxBitCount + 4'd1;
            if ((rxBitCount == 4'd0 && rxIn) || rxDone) begin
               rxBusy <= 1'b0; // glitch on start, or frame complete
            end
         end
         if (rxDone) begin
            rxValid <= 1'b1;
         end else if (link.rxTake) begin
            rxValid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rxSample && rxBitCount != 4'd0 && !rxDone) begin
         rxByte <= {rxIn, rxByte[7:1]}; // lsb first
      end
      if (rxDone) begin
         rxHold <= rxByte;
      end
   end

   assign link.rxData  = rxHold;
   assign link.rxValid = rxValid;

endmodule

`default_nettype wire

// File: src/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
   parameter int TxDepth = 4
) (
   input  wire                 clk,
   input  wire                 reset,
   input  wire                 stall,
   input  wire                 irWrite,
   input  wire                 pcWrite,
   input  mipsPkg::PcSel       pcSel,
   input  wire                 regWrite,
   input  wire                 regDst,
   input  wire                 aluSrcImm,
   input  wire                 signExtend,
   input  mipsPkg::AluOp       aluOp,
   input  wire                 memToReg,
   input  wire                 addrLatch,
   input  wire                 ioRead,
   input  wire                 ioWrite,
   input  wire [31:0]          dcacheDout,
   input  wire [31:0]          instruction,
   input  wire [31:0]          count,
   output mipsPkg::Instruction instr,
   output logic                branchEqual,
   output logic                isIo,
   output logic [31:0]         icacheAddr,
   output logic [31:0]         dcacheAddr,
   output logic [31:0]         dcacheDin,
   output logic                counterClear,
   uartLink.core               link
);
   import mipsPkg::*;

   localparam int CreditWidth = $clog2(TxDepth + 1);

   logic [31:0] pc;
   logic [31:0] regs [32];
   logic [31:0] rsVal;
   logic [31:0] rtVal;
   logic [31:0] immExt;
   logic [31:0] aluB;
   logic [31:0] aluResult;
   logic [31:0] aluOut;
   logic [31:0] addr;
   logic [31:0] ioData;
   logic [31:0] wbData;
   logic [4:0]  wrReg;
   logic [CreditWidth-1:0] credits;
   logic        hasCredit;
   logic        txPush;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (pcWrite && !stall) begin
         case (pcSel)
            PcBranch: pc <= pc + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00}; // pc already +4
            PcJump:   pc <= {pc[31:28], instr.j.target, 2'b00};
            default:  pc <= pc + 32'd4;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         if (irWrite) begin
            instr <= instruction;
         end
         if (addrLatch) begin
            addr <= aluResult;
         end
         aluOut <= aluResult;
      end
   end

   // register 0 reads as zero
   assign rsVal = (instr.r.rs == 5'd0) ? '0 : regs[instr.r.rs];
   assign rtVal = (instr.r.rt == 5'd0) ? '0 : regs[instr.r.rt];
   assign wrReg = regDst ? instr.r.rd : instr.r.rt;

   always_ff @(posedge clk) begin
      if (regWrite && !stall && wrReg != 5'd0) begin
         regs[wrReg] <= wbData;
      end
   end

   assign immExt = {{16{signExtend & instr.i.imm[15]}}, instr.i.imm};
   assign aluB   = aluSrcImm ? immExt : rtVal;

   always_comb begin
      case (aluOp)
         AluAdd:  aluResult = rsVal + aluB;
         AluSub:  aluResult = rsVal - aluB;
         AluAnd:  aluResult = rsVal & aluB;
         AluOr:   aluResult = rsVal | aluB;
         AluSlt:  aluResult = {31'd0, $signed(rsVal) < $signed(aluB)};
         AluLui:  aluResult = {aluB[15:0], 16'd0};
         default: aluResult = aluB;
      endcase
   end

   assign branchEqual = (rsVal == rtVal);
   assign isIo        = (addr[31:28] == IoBase[31:28]);
   assign icacheAddr  = pc;
   assign dcacheAddr  = addr;
   assign dcacheDin   = rtVal;

   always_comb begin
      case (addr)
         IoStatus: ioData = {30'd0, link.rxValid, hasCredit};
         IoRxData: ioData = {24'd0, link.rxData};
         IoCount:  ioData = count;
         default:  ioData = '0;
      endcase
   end

   assign wbData = memToReg ? (isIo ? ioData : dcacheDout) : aluOut;

   assign hasCredit    = (credits != '0);
   assign txPush       = ioWrite && !stall && addr == IoTxData && hasCredit; // no credit, dropped
   assign counterClear = ioWrite && !stall && addr == IoCountClear;
   assign link.txPush  = txPush;
   assign link.txData  = rtVal[7:0];
   assign link.rxTake  = ioRead && !stall && addr == IoRxData;

   always_ff @(posedge clk) begin
      if (reset) begin
         credits <= CreditWidth'(TxDepth);
      end else if (txPush && !link.txCredit) begin
         credits <= credits - 1'b1;
      end else if (link.txCredit && !txPush) begin
         credits <= credits + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: src/cycleCounter.sv
`timescale 1ns/1ps
`default_nettype none

module cycleCounter (
   input  wire         clk,
   input  wire         reset,
   input  wire         clear,
   output logic [31:0] count
);

   always_ff @(posedge clk) begin
      if (reset || clear) begin
         count <= '0;
      end else begin
         count <= count + 32'd1; // wraps
      end
   end

endmodule

`default_nettype wire

// File: src/controlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module controlFsm (
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     stall,
   input  mipsPkg::Instruction     instr,
   input  wire                     branchEqual,
   input  wire                     isIo,
   output logic                    irWrite,
   output logic                    pcWrite,
   output mipsPkg::PcSel           pcSel,
   output logic                    regWrite,
   output logic                    regDst,
   output logic                    aluSrcImm,
   output logic                    signExtend,
   output mipsPkg::AluOp           aluOp,
   output logic                    memToReg,
   output logic                    addrLatch,
   output logic                    ioRead,
   output logic                    ioWrite,
   output logic                    icacheRe,
   output logic                    dcacheRe,
   output logic [3:0]              dcacheWe
);
   import mipsPkg::*;

   typedef enum logic [2:0] {
      Fetch,
      Decode,
      Execute,
      Memory,
      Writeback
   } State;

   State state;
   State nextState;
   logic isMem;
   logic isBranch;
   logic taken;

   assign isMem    = (instr.r.opcode == OpLw) || (instr.r.opcode == OpSw);
   assign isBranch = (instr.r.opcode == OpBeq) || (instr.r.opcode == OpBne);
   assign taken    = (instr.r.opcode == OpBeq) ? branchEqual : !branchEqual;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= Fetch;
      end else if (!stall) begin
         state <= nextState;
      end
   end

   always_comb begin
      case (state)
         Fetch:     nextState = Decode;
         Decode:    nextState = Execute;
         Execute: begin
            if (isMem) begin
               nextState = Memory;
            end else if (isBranch || instr.r.opcode == OpJ) begin
               nextState = Fetch;
            end else begin
               nextState = Writeback;
            end
         end
         Memory:    nextState = (instr.r.opcode == OpLw) ? Writeback : Fetch;
         default:   nextState = Fetch;
      endcase
   end

   // field decode, only takes effect where a state writes
   always_comb begin
      regDst     = (instr.r.opcode == OpRType);
      aluSrcImm  = (instr.r.opcode != OpRType);
      signExtend = (instr.r.opcode != OpOri);
      case (instr.r.opcode)
         OpRType: begin
            case (instr.r.funct)
               FnAddu:  aluOp = AluAdd;
               FnSubu:  aluOp = AluSub;
               FnAnd:   aluOp = AluAnd;
               FnOr:    aluOp = AluOr;
               FnSlt:   aluOp = AluSlt;
               default: aluOp = AluPassB;
            endcase
         end
         OpOri:   aluOp = AluOr;
         OpLui:   aluOp = AluLui;
         OpAddiu, OpLw, OpSw: aluOp = AluAdd;
         default: aluOp = AluPassB;
      endcase
   end

   always_comb begin
      irWrite   = 1'b0;
      pcWrite   = 1'b0;
      pcSel     = PcPlus4;
      regWrite  = 1'b0;
      memToReg  = 1'b0;
      addrLatch = 1'b0;
      ioRead    = 1'b0;
      ioWrite   = 1'b0;
      icacheRe  = 1'b0;
      dcacheRe  = 1'b0;
      dcacheWe  = 4'b0000;
      case (state)
         Fetch:   icacheRe = 1'b1;
         Decode: begin
            irWrite = 1'b1; // word arrives this cycle
            pcWrite = 1'b1;
         end
         Execute: begin
            addrLatch = isMem;
            if (instr.r.opcode == OpJ) begin
               pcWrite = 1'b1;
               pcSel   = PcJump;
            end else if (isBranch) begin
               pcWrite = taken;
               pcSel   = PcBranch;
            end
         end
         Memory: begin
            if (instr.r.opcode == OpLw) begin
               dcacheRe = !isIo;
            end else begin
               dcacheWe = isIo ? 4'b0000 : 4'b1111;
               ioWrite  = isIo;
            end
         end
         Writeback: begin
            regWrite = 1'b1;
            memToReg = (instr.r.opcode == OpLw);
            ioRead   = (instr.r.opcode == OpLw) && isIo;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: src/uartLink.sv
`timescale 1ns/1ps
`default_nettype none

interface uartLink;
   logic [7:0] txData;
   logic       txPush;
   logic       txCredit; // one credit back per dequeued byte
   logic [7:0] rxData;
   logic       rxValid;
   logic       rxTake;

   modport core (
      output txData, txPush, rxTake,
      input  txCredit, rxData, rxValid
   );

   modport serial (
      input  txData, txPush, rxTake,
      output txCredit, rxData, rxValid
   );
endinterface

`default_nettype wire

// File: src/mipsPkg.sv
`default_nettype none

package mipsPkg;

   typedef enum logic [5:0] {
      OpRType = 6'h00,
      OpJ     = 6'h02,
      OpBeq   = 6'h04,
      OpBne   = 6'h05,
      OpAddiu = 6'h09,
      OpOri   = 6'h0d,
      OpLui   = 6'h0f,
      OpLw    = 6'h23,
      OpSw    = 6'h2b
   } Opcode;

   typedef enum logic [5:0] {
      FnAddu = 6'h21,
      FnSubu = 6'h23,
      FnAnd  = 6'h24,
      FnOr   = 6'h25,
      FnSlt  = 6'h2a
   } Funct;

   typedef enum logic [2:0] {
      AluAdd,
      AluSub,
      AluAnd,
      AluOr,
      AluSlt,
      AluLui,
      AluPassB
   } AluOp;

   typedef enum logic [1:0] {
      PcPlus4,
      PcBranch,
      PcJump
   } PcSel;

   typedef struct packed {
      Opcode      opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      Funct       funct;
   } RFormat;

   typedef struct packed {
      Opcode       opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } IFormat;

   typedef struct packed {
      Opcode       opcode;
      logic [25:0] target;
   } JFormat;

   // one fetched word, three field layouts
   typedef union packed {
      RFormat r;
      IFormat i;
      JFormat j;
   } Instruction;

   localparam logic [31:0] IoBase       = 32'h8000_0000; // top nibble selects I/O
   localparam logic [31:0] IoStatus     = 32'h8000_0000;
   localparam logic [31:0] IoRxData     = 32'h8000_0004;
   localparam logic [31:0] IoTxData     = 32'h8000_0008;
   localparam logic [31:0] IoCount      = 32'h8000_0010;
   localparam logic [31:0] IoCountClear = 32'h8000_0018;

endpackage

`default_nettype wire
